//--- src/pipe_pkg.sv
/*
 * Pipeline package
 * Shared widths, RV32I opcodes, decode enums and the stage payloads
 */
package pipe_pkg;

    typedef logic [31:0] xlen_t;    // One machine word
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;

    // ----------------------------------------
    // Opcodes of the supported subset
    // ----------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B                  // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } br_kind_e;

    // ----------------------------------------
    // Stage payloads
    // ----------------------------------------
    typedef struct packed {
        pc_t    pc;
        instr_t instr;
    } fetch_s;

    typedef struct packed {
        pc_t       pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;         // Immediate as second operand
        br_kind_e  br_kind;
        logic      rd_we;
        logic      illegal;
    } exu_cmd_s;

    typedef struct packed {
        pc_t       pc;
        reg_addr_t rd;
        xlen_t     value;
        logic      we;
        logic      illegal;
    } result_s;

    // External retire record, kept apart from the internal result
    typedef struct packed {
        pc_t       pc;
        reg_addr_t rd;
        xlen_t     value;
        logic      we;
        logic      illegal;
    } retire_s;

endpackage : pipe_pkg

//--- src/pipe_ifu.sv
/*
 * Instruction fetch unit
 * Issues one memory request at a time and buffers one instruction for decode
 */
`timescale 1ns/1ns

module pipe_ifu #(
    parameter pipe_pkg::pc_t RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_imem_ack,
    input  logic             i_imem_resp_valid,
    input  pipe_pkg::instr_t i_imem_rdata,
    input  logic             i_redirect,
    input  pipe_pkg::pc_t    i_redirect_pc,
    input  logic             i_fetch_ready,
    output logic             o_imem_req,
    output pipe_pkg::pc_t    o_imem_addr,
    output logic             o_fetch_valid,
    output pipe_pkg::fetch_s o_fetch
);

import pipe_pkg::*;

typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
} ifu_state_e;

ifu_state_e state;
ifu_state_e state_next;
pc_t        pc_q;                   // Address of the current request
pc_t        redir_pc_q;             // Target held while a stale response is due
logic       stale;
logic       buf_valid;
fetch_s     fetch_buf;
logic       buf_free;
logic       resp_last;              // Response for the outstanding request
logic       resp_take;

assign buf_free  = ~buf_valid | i_fetch_ready | i_redirect;
assign resp_last = (state == ST_WAIT) & i_imem_resp_valid;
assign resp_take = resp_last & ~stale & ~i_redirect;

// ----------------------------------------
// Request FSM
// ----------------------------------------
always_comb begin
    state_next = state;
    case (state)
        ST_IDLE: if (buf_free)          state_next = ST_REQ;
        ST_REQ:  if (i_imem_ack)        state_next = ST_WAIT;
        ST_WAIT: if (i_imem_resp_valid) state_next = ST_IDLE;
        default:                        state_next = ST_IDLE;
    endcase
end

always_ff @(posedge clk) begin
    if (i_reset) begin
        state <= ST_IDLE;
        pc_q  <= RESET_PC;
        stale <= 1'b0;
    end else begin
        state <= state_next;
        if (resp_last) begin
            stale <= 1'b0;
            if (i_redirect) begin
                pc_q <= i_redirect_pc;              // Response is wrong path
            end else if (stale) begin
                pc_q <= redir_pc_q;
            end else begin
                pc_q <= pc_q + 32'd4;
            end
        end else if (i_redirect) begin
            if (state == ST_IDLE) begin
                pc_q <= i_redirect_pc;
            end else begin
                stale <= 1'b1;                      // Address must hold until ack
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (i_redirect) begin
        redir_pc_q <= i_redirect_pc;
    end
end

// ----------------------------------------
// Fetch buffer
// ----------------------------------------
always_ff @(posedge clk) begin
    if (i_reset) begin
        buf_valid <= 1'b0;
    end else if (i_redirect) begin
        buf_valid <= 1'b0;
    end else if (resp_take) begin
        buf_valid <= 1'b1;
    end else if (i_fetch_ready) begin
        buf_valid <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (resp_take) begin
        fetch_buf.pc    <= pc_q;
        fetch_buf.instr <= i_imem_rdata;
    end
end

assign o_imem_req    = (state == ST_REQ);
assign o_imem_addr   = pc_q;
assign o_fetch_valid = buf_valid;
assign o_fetch       = fetch_buf;

endmodule : pipe_ifu

//--- src/pipe_idu.sv
/*
 * Instruction decode unit
 * Turns each RV32I word into an execute command and holds it in the stage register
 */
`timescale 1ns/1ns

module pipe_idu (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_fetch_valid,
    input  pipe_pkg::fetch_s   i_fetch,
    input  logic               i_flush,
    input  logic               i_cmd_ready,
    output logic               o_fetch_ready,
    output logic               o_cmd_valid,
    output pipe_pkg::exu_cmd_s o_cmd
);

import pipe_pkg::*;

instr_t     instr;
logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;
logic       f7_zero;
logic       f7_alt;                 // SUB and SRA encoding
xlen_t      imm_i;
xlen_t      imm_u;
xlen_t      imm_b;
xlen_t      imm_j;
logic       illegal;
exu_cmd_s   dec;
exu_cmd_s   cmd_q;
logic       cmd_valid_q;

function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    case (f3)
        3'b000:  return alt ? ALU_SUB : ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_SLT;
        3'b011:  return ALU_SLTU;
        3'b100:  return ALU_XOR;
        3'b101:  return alt ? ALU_SRA : ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

assign instr   = i_fetch.instr;
assign opcode  = instr[6:0];
assign funct3  = instr[14:12];
assign funct7  = instr[31:25];
assign f7_zero = (funct7 == 7'b0000000);
assign f7_alt  = (funct7 == 7'b0100000);

assign imm_i = {{20{instr[31]}}, instr[31:20]};
assign imm_u = {instr[31:12], 12'b0};
assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

// ----------------------------------------
// Decoder
// ----------------------------------------
always_comb begin
    dec         = '0;
    dec.pc      = i_fetch.pc;
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.rd      = instr[11:7];
    dec.alu_op  = ALU_ADD;
    dec.br_kind = BR_NONE;
    illegal     = 1'b0;
    case (opcode)
        OPC_OP: begin
            dec.alu_op = f3_to_alu(funct3, f7_alt);
            dec.rd_we  = 1'b1;
            illegal    = ~(f7_zero | (f7_alt & (funct3 == 3'b000 | funct3 == 3'b101)));
        end
        OPC_OP_IMM: begin
            dec.alu_op  = f3_to_alu(funct3, f7_alt & (funct3 == 3'b101));
            dec.imm     = imm_i;
            dec.use_imm = 1'b1;
            dec.rd_we   = 1'b1;
            illegal     = ((funct3 == 3'b001) & ~f7_zero)
                        | ((funct3 == 3'b101) & ~(f7_zero | f7_alt));
        end
        OPC_LUI: begin
            dec.alu_op  = ALU_PASS_B;
            dec.imm     = imm_u;
            dec.use_imm = 1'b1;
            dec.rd_we   = 1'b1;
        end
        OPC_BRANCH: begin
            dec.imm     = imm_b;
            dec.br_kind = (funct3[0]) ? BR_BNE : BR_BEQ;
            illegal     = (funct3[2:1] != 2'b00);
        end
        OPC_JAL: begin
            dec.imm     = imm_j;
            dec.br_kind = BR_JAL;
            dec.rd_we   = 1'b1;
        end
        default: illegal = 1'b1;
    endcase
    if (illegal) begin
        dec.rd_we   = 1'b0;         // Retired with no side effects
        dec.br_kind = BR_NONE;
    end
    dec.illegal = illegal;
end

// ----------------------------------------
// Stage register
// ----------------------------------------
assign o_fetch_ready = ~cmd_valid_q | i_cmd_ready;

always_ff @(posedge clk) begin
    if (i_reset) begin
        cmd_valid_q <= 1'b0;
    end else if (i_flush) begin
        cmd_valid_q <= 1'b0;        // Wrong path after a redirect
    end else if (o_fetch_ready) begin
        cmd_valid_q <= i_fetch_valid;
    end
end

always_ff @(posedge clk) begin
    if (o_fetch_ready & i_fetch_valid) begin
        cmd_q <= dec;
    end
end

assign o_cmd_valid = cmd_valid_q;
assign o_cmd       = cmd_q;

endmodule : pipe_idu

//--- src/pipe_exu.sv
/*
 * Execution unit
 * ALU, branch and jump resolution, and the result stage register
 */
`timescale 1ns/1ns

module pipe_exu (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_cmd_valid,
    input  pipe_pkg::exu_cmd_s  i_cmd,
    input  pipe_pkg::xlen_t     i_rs1_data,
    input  pipe_pkg::xlen_t     i_rs2_data,
    output logic                o_cmd_ready,
    output pipe_pkg::reg_addr_t o_rs1_addr,
    output pipe_pkg::reg_addr_t o_rs2_addr,
    output logic                o_redirect,
    output pipe_pkg::pc_t       o_redirect_pc,
    output logic                o_result_valid,
    output pipe_pkg::result_s   o_result
);

import pipe_pkg::*;

xlen_t    op_a;
xlen_t    op_b;
logic [4:0] shamt;
xlen_t    alu_res;
xlen_t    wr_value;
pc_t      pc_plus4;
pc_t      br_target;
logic     rs_equal;
logic     taken;
logic     cmd_fire;
logic     result_valid_q;
result_s  result_q;
logic     redirect_q;
pc_t      redirect_pc_q;

// Every command completes in one cycle
assign o_cmd_ready = 1'b1;
assign o_rs1_addr  = i_cmd.rs1;
assign o_rs2_addr  = i_cmd.rs2;

assign op_a  = i_rs1_data;
assign op_b  = i_cmd.use_imm ? i_cmd.imm : i_rs2_data;
assign shamt = op_b[4:0];

// ----------------------------------------
// ALU
// ----------------------------------------
always_comb begin
    case (i_cmd.alu_op)
        ALU_ADD:    alu_res = op_a + op_b;
        ALU_SUB:    alu_res = op_a - op_b;
        ALU_AND:    alu_res = op_a & op_b;
        ALU_OR:     alu_res = op_a | op_b;
        ALU_XOR:    alu_res = op_a ^ op_b;
        ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
        ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
        ALU_SLL:    alu_res = op_a << shamt;
        ALU_SRL:    alu_res = op_a >> shamt;
        ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
        ALU_PASS_B: alu_res = op_b;
        default:    alu_res = op_a + op_b;
    endcase
end

// ----------------------------------------
// Branch resolution
// ----------------------------------------
assign pc_plus4  = i_cmd.pc + 32'd4;
assign br_target = i_cmd.pc + i_cmd.imm;
assign rs_equal  = (i_rs1_data == i_rs2_data);

always_comb begin
    case (i_cmd.br_kind)
        BR_BEQ:  taken = rs_equal;
        BR_BNE:  taken = ~rs_equal;
        BR_JAL:  taken = 1'b1;
        default: taken = 1'b0;
    endcase
end

// JAL links the return address
assign wr_value = (i_cmd.br_kind == BR_JAL) ? pc_plus4 : alu_res;

// A command arriving next to a redirect is already on the wrong path
assign cmd_fire = i_cmd_valid & o_cmd_ready & ~redirect_q;

// ----------------------------------------
// Result register
// ----------------------------------------
always_ff @(posedge clk) begin
    if (i_reset) begin
        result_valid_q <= 1'b0;
        redirect_q     <= 1'b0;
    end else begin
        result_valid_q <= cmd_fire;
        redirect_q     <= cmd_fire & taken;
    end
end

always_ff @(posedge clk) begin
    if (cmd_fire) begin
        result_q.pc      <= i_cmd.pc;
        result_q.rd      <= i_cmd.rd;
        result_q.value   <= i_cmd.rd_we ? wr_value : '0;    // Zero when nothing is written
        result_q.we      <= i_cmd.rd_we;
        result_q.illegal <= i_cmd.illegal;
        redirect_pc_q    <= br_target;
    end
end

assign o_result_valid = result_valid_q;
assign o_result       = result_q;
assign o_redirect     = redirect_q;
assign o_redirect_pc  = redirect_pc_q;

endmodule : pipe_exu

//--- src/pipe_wbu.sv
/*
 * Result stage
 * Register file with write-through reads and the retire report
 */
`timescale 1ns/1ns

module pipe_wbu (
    input  logic                clk,
    input  logic                i_reset,
    input  pipe_pkg::reg_addr_t i_rs1_addr,
    input  pipe_pkg::reg_addr_t i_rs2_addr,
    input  logic                i_result_valid,
    input  pipe_pkg::result_s   i_result,
    output pipe_pkg::xlen_t     o_rs1_data,
    output pipe_pkg::xlen_t     o_rs2_data,
    output logic                o_retire_valid,
    output pipe_pkg::retire_s   o_retire
);

import pipe_pkg::*;

xlen_t regs [1:31];                 // x0 is not stored
logic  wr_en;

// Same-cycle write is passed to the reader
function automatic xlen_t read_reg(input reg_addr_t addr);
    if (addr == '0) begin
        return '0;
    end else if (wr_en && (addr == i_result.rd)) begin
        return i_result.value;
    end
    return regs[addr];
endfunction

assign wr_en = i_result_valid & i_result.we & ~i_result.illegal
             & (i_result.rd != '0) & ~i_reset;

always_ff @(posedge clk) begin
    if (wr_en) begin
        regs[i_result.rd] <= i_result.value;
    end
end

assign o_rs1_data = read_reg(i_rs1_addr);
assign o_rs2_data = read_reg(i_rs2_addr);

// ----------------------------------------
// Retire report
// ----------------------------------------
assign o_retire_valid   = i_result_valid;
assign o_retire.pc      = i_result.pc;
assign o_retire.rd      = i_result.rd;
assign o_retire.value   = i_result.value;
assign o_retire.we      = i_result.we;
assign o_retire.illegal = i_result.illegal;

endmodule : pipe_wbu

//--- src/pipe_top.sv
/*
 * Pipeline top
 * Joins fetch, decode, execute and the result stage of the RV32I core
 */
`timescale 1ns/1ns

module pipe_top #(
    parameter pipe_pkg::pc_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_imem_ack,
    input  logic              i_imem_resp_valid,
    input  pipe_pkg::instr_t  i_imem_rdata,
    output logic              o_imem_req,
    output pipe_pkg::pc_t     o_imem_addr,
    output logic              o_retire_valid,
    output pipe_pkg::retire_s o_retire
);

import pipe_pkg::*;

// ----------------------------------------
// Stage interconnect
// ----------------------------------------
logic      fetch_valid;             // IFU to IDU
fetch_s    fetch;
logic      fetch_ready;
logic      cmd_valid;               // IDU to EXU
exu_cmd_s  cmd;
logic      cmd_ready;
reg_addr_t rs1_addr;                // EXU register reads
reg_addr_t rs2_addr;
xlen_t     rs1_data;
xlen_t     rs2_data;
logic      redirect;
pc_t       redirect_pc;
logic      result_valid;            // EXU to WBU
result_s   result;

pipe_ifu #(
    .RESET_PC (RESET_PC)
) pipe_ifu_i (
    .clk               (clk              ),
    .i_reset           (i_reset          ),
    .i_imem_ack        (i_imem_ack       ),
    .i_imem_resp_valid (i_imem_resp_valid),
    .i_imem_rdata      (i_imem_rdata     ),
    .i_redirect        (redirect         ),
    .i_redirect_pc     (redirect_pc      ),
    .i_fetch_ready     (fetch_ready      ),
    .o_imem_req        (o_imem_req       ),
    .o_imem_addr       (o_imem_addr      ),
    .o_fetch_valid     (fetch_valid      ),
    .o_fetch           (fetch            )
);

pipe_idu pipe_idu_i (
    .clk           (clk        ),
    .i_reset       (i_reset    ),
    .i_fetch_valid (fetch_valid),
    .i_fetch       (fetch      ),
    .i_flush       (redirect   ),
    .i_cmd_ready   (cmd_ready  ),
    .o_fetch_ready (fetch_ready),
    .o_cmd_valid   (cmd_valid  ),
    .o_cmd         (cmd        )
);

pipe_exu pipe_exu_i (
    .clk            (clk         ),
    .i_reset        (i_reset     ),
    .i_cmd_valid    (cmd_valid   ),
    .i_cmd          (cmd         ),
    .i_rs1_data     (rs1_data    ),
    .i_rs2_data     (rs2_data    ),
    .o_cmd_ready    (cmd_ready   ),
    .o_rs1_addr     (rs1_addr    ),
    .o_rs2_addr     (rs2_addr    ),
    .o_redirect     (redirect    ),
    .o_redirect_pc  (redirect_pc ),
    .o_result_valid (result_valid),
    .o_result       (result      )
);

pipe_wbu pipe_wbu_i (
    .clk            (clk           ),
    .i_reset        (i_reset       ),
    .i_rs1_addr     (rs1_addr      ),
    .i_rs2_addr     (rs2_addr      ),
    .i_result_valid (result_valid  ),
    .i_result       (result        ),
    .o_rs1_data     (rs1_data      ),
    .o_rs2_data     (rs2_data      ),
    .o_retire_valid (o_retire_valid),
    .o_retire       (o_retire      )
);

endmodule : pipe_top

//--- sim/tb_clock.sv
/*
 * Testbench clock
 * Free-running clock with a fixed period
 */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic o_clk
);

initial begin
    o_clk = 1'b0;
    forever begin
        #(PERIOD_NS / 2) o_clk = ~o_clk;
    end
end

endmodule : tb_clock

//--- sim/tb_pipe_top.sv
/*
 * Testbench for the RV32I pipeline top
 * Random program behind an instruction memory with random latency,
 * every retire compared with a sequential ISA model
 */
`timescale 1ns/1ns

module tb_pipe_top;

import pipe_pkg::*;

localparam pc_t         RESET_PC     = 32'h0000_1000;
localparam int          PROG_LEN     = 200;
localparam int          INIT_REGS    = 7;           // x1 to x7 get a start value
localparam int          RESET_CYCLES = 8;
localparam int          CLK_PERIOD   = 8;
localparam int unsigned RAND_SEED    = 32'hc10d8f60;
localparam int          TIMEOUT_NS   = (PROG_LEN * 12 + RESET_CYCLES) * CLK_PERIOD;

logic    clk;
logic    reset;
logic    imem_ack;
logic    imem_resp_valid;
instr_t  imem_rdata;
logic    imem_req;
pc_t     imem_addr;
logic    retire_valid;
retire_s retire;

instr_t  prog [PROG_LEN];
xlen_t   ref_regs [32];
retire_s exp_q [$];                 // Retire records still to come
int      checks;
int      errors;

tb_clock #(
    .PERIOD_NS (CLK_PERIOD)
) tb_clock_i (
    .o_clk (clk)
);

pipe_top #(
    .RESET_PC (RESET_PC)
) pipe_top_i (
    .clk               (clk            ),
    .i_reset           (reset          ),
    .i_imem_ack        (imem_ack       ),
    .i_imem_resp_valid (imem_resp_valid),
    .i_imem_rdata      (imem_rdata     ),
    .o_imem_req        (imem_req       ),
    .o_imem_addr       (imem_addr      ),
    .o_retire_valid    (retire_valid   ),
    .o_retire          (retire         )
);

// ----------------------------------------
// Checks and report
// ----------------------------------------
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
        $display("Error: %s expected %h actual %h", name, expected, actual);
        errors++;
    end
endtask

task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
        $display("%s", what);
        errors++;
    end
endtask

task automatic report_and_finish(input logic timed_out);
    $display("Checks: %0d, errors: %0d, retires missing: %0d", checks, errors, exp_q.size());
    if (!timed_out && errors == 0 && exp_q.size() == 0) begin
        $display("ALL CHECKS PASSED");
    end else begin
        $display("CHECKS FAILED");
    end
    $finish;
endtask

// ----------------------------------------
// Program assembly
// ----------------------------------------
function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                 input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                 input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic instr_t enc_b(input logic [12:0] off, input reg_addr_t rs1,
                                 input reg_addr_t rs2, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic instr_t enc_j(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// Words outside the program only show up on the wrong path
function automatic instr_t mem_word(input pc_t addr);
    pc_t off;
    int  idx;
    off = addr - RESET_PC;
    idx = int'(off >> 2);
    if (off < PROG_LEN * 4) begin
        return prog[idx];
    end
    return addr ^ 32'h5a5a_a5a5;
endfunction

task automatic build_program;
    logic [31:0] rnd;
    logic [31:0] imm_rnd;
    logic [11:0] imm12;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        alt;
    int          step;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
        rnd     = $urandom;
        imm_rnd = $urandom;
        rd      = {2'b00, rnd[2:0]};    // Few registers, many dependencies
        rs1     = {2'b00, rnd[5:3]};
        rs2     = {2'b00, rnd[8:6]};
        f3      = rnd[11:9];
        alt     = rnd[19];
        f7      = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        step    = 1 + int'(rnd[17:16]);
        if (i + step > PROG_LEN - 1) begin
            step = PROG_LEN - 1 - i;    // Never jump past the last word
        end
        if (f3 == 3'b001) begin
            imm12 = {7'h00, imm_rnd[4:0]};
        end else if (f3 == 3'b101) begin
            imm12 = {f7, imm_rnd[4:0]};
        end else begin
            imm12 = imm_rnd[11:0];
        end
        if (i < INIT_REGS) begin
            prog[i] = enc_i(imm_rnd[11:0], 5'd0, 3'b000, 5'(i + 1), OPC_OP_IMM);
        end else begin
            case (rnd[15:12])
                4'd6, 4'd7, 4'd8, 4'd9: prog[i] = enc_i(imm12, rs1, f3, rd, OPC_OP_IMM);
                4'd10, 4'd11:           prog[i] = {imm_rnd[19:0], rd, OPC_LUI};
                4'd12, 4'd13: begin
                    // Equal operands half the time so BEQ and BNE both go either way
                    prog[i] = enc_b(13'(step * 4), rs1, rnd[18] ? rs1 : rs2, {2'b00, alt});
                end
                4'd14:                  prog[i] = enc_j(21'(step * 4), rd);
                4'd15: begin
                    case (rnd[17:16])
                        2'd0:    prog[i] = {imm_rnd[31:7], 7'b0000011};     // Load
                        2'd1:    prog[i] = enc_r(7'h01, f3, rd, rs1, rs2);  // M extension
                        2'd2:    prog[i] = enc_b(13'(step * 4), rs1, rs2, {1'b1, f3[1:0]});
                        default: prog[i] = enc_i({7'h20, imm_rnd[4:0]}, rs1, 3'b001, rd,
                                                 OPC_OP_IMM);
                    endcase
                end
                default:                prog[i] = enc_r(f7, f3, rd, rs1, rs2);
            endcase
        end
    end
    prog[PROG_LEN - 1] = enc_j(21'd0, 5'd0);    // Self loop ends the program
endtask

// ----------------------------------------
// ISA reference model
// ----------------------------------------
function automatic xlen_t ref_alu(input logic [2:0] f3, input logic alt,
                                  input xlen_t a, input xlen_t b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101: begin
            if (alt) begin
                return sa >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

task automatic ref_step(input pc_t pc, output retire_s rec, output pc_t next_pc);
    instr_t     w;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm;
    logic       legal;
    w       = mem_word(pc);
    opc     = w[6:0];
    f3      = w[14:12];
    f7      = w[31:25];
    a       = ref_regs[w[19:15]];
    b       = ref_regs[w[24:20]];
    rec     = '0;
    rec.pc  = pc;
    rec.rd  = w[11:7];
    next_pc = pc + 32'd4;
    legal   = 1'b1;
    case (opc)
        OPC_OP: begin
            legal     = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
            rec.value = ref_alu(f3, f7[5], a, b);
        end
        OPC_OP_IMM: begin
            imm = {{20{w[31]}}, w[31:20]};
            if (f3 == 3'b001) begin
                legal = (f7 == 7'h00);
            end else if (f3 == 3'b101) begin
                legal = (f7 == 7'h00) || (f7 == 7'h20);
            end
            rec.value = ref_alu(f3, (f3 == 3'b101) && f7[5], a, imm);
        end
        OPC_LUI: rec.value = {w[31:12], 12'b0};
        OPC_BRANCH: begin
            legal = (f3[2:1] == 2'b00);
            imm   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            if (legal && ((a == b) != f3[0])) begin
                next_pc = pc + imm;
            end
        end
        OPC_JAL: begin
            rec.value = pc + 32'd4;
            next_pc   = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        default: legal = 1'b0;
    endcase
    rec.we      = legal && (opc != OPC_BRANCH);
    rec.illegal = ~legal;
    if (!rec.we) begin
        rec.value = '0;
    end
    if (rec.we && rec.rd != 5'd0) begin
        ref_regs[rec.rd] = rec.value;
    end
endtask

task automatic run_model;
    pc_t     pc;
    pc_t     next_pc;
    retire_s rec;
    foreach (ref_regs[i]) begin
        ref_regs[i] = '0;
    end
    pc = RESET_PC;
    for (int steps = 0; steps <= PROG_LEN; steps++) begin
        ref_step(pc, rec, next_pc);
        exp_q.push_back(rec);
        if (next_pc == pc) begin
            break;
        end
        pc = next_pc;
    end
endtask

task automatic compare_retire(input retire_s exp, input retire_s act);
    string at;
    at = $sformatf("@%h", exp.pc);
    check_value("retire_pc", exp.pc, act.pc);
    check_value({"retire_rd ", at}, 32'(exp.rd), 32'(act.rd));
    check_value({"retire_value ", at}, exp.value, act.value);
    check_value({"retire_we ", at}, 32'(exp.we), 32'(act.we));
    check_value({"retire_illegal ", at}, 32'(exp.illegal), 32'(act.illegal));
endtask

// ----------------------------------------
// Instruction memory model
// ----------------------------------------
initial begin : imem_model
    int   ack_wait;
    int   resp_wait;
    logic ack_armed;
    logic resp_busy;
    logic req_waiting;              // Request seen but not acknowledged
    logic first_ack;
    pc_t  resp_addr;
    pc_t  held_addr;
    imem_ack        = 1'b0;
    imem_resp_valid = 1'b0;
    imem_rdata      = '0;
    ack_wait        = 0;
    resp_wait       = 0;
    ack_armed       = 1'b0;
    resp_busy       = 1'b0;
    req_waiting     = 1'b0;
    first_ack       = 1'b1;
    resp_addr       = '0;
    held_addr       = '0;
    forever begin
        @(posedge clk);
        #1;
        imem_ack        = 1'b0;
        imem_resp_valid = 1'b0;
        if (req_waiting) begin
            check_true(imem_req, "Instruction request dropped before it was acknowledged");
            check_value("addr_stable", held_addr, imem_addr);
        end
        req_waiting = 1'b0;
        if (resp_busy) begin
            resp_wait--;
            if (resp_wait == 0) begin
                imem_resp_valid = 1'b1;
                imem_rdata      = mem_word(resp_addr);
                resp_busy       = 1'b0;
            end
        end else if (imem_req) begin
            if (!ack_armed) begin
                ack_wait  = int'($urandom_range(3, 0));
                ack_armed = 1'b1;
            end
            if (ack_wait == 0) begin
                imem_ack  = 1'b1;
                ack_armed = 1'b0;
                if (first_ack) begin
                    check_value("first_fetch_pc", RESET_PC, imem_addr);
                end
                first_ack = 1'b0;
                resp_addr = imem_addr;
                resp_wait = 1 + int'($urandom_range(3, 0));    // 1 to 4 cycles
                resp_busy = 1'b1;
            end else begin
                ack_wait--;
                req_waiting = 1'b1;
                held_addr   = imem_addr;
            end
        end
    end
end

// ----------------------------------------
// Main sequence and watchdog
// ----------------------------------------
initial begin : main_seq
    retire_s     exp_rec;
    reset    = 1'b1;
    checks   = 0;
    errors   = 0;
    void'($urandom(RAND_SEED));
    build_program();
    run_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_true(!retire_valid, "Retire valid was high in the first cycle after reset");
    check_true(!imem_req, "Instruction request was high in the first cycle after reset");
    while (exp_q.size() > 0) begin
        @(negedge clk);
        if (retire_valid) begin
            exp_rec = exp_q.pop_front();
            compare_retire(exp_rec, retire);
        end
    end
    report_and_finish(1'b0);
end

initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, %0d retires never came", TIMEOUT_NS, exp_q.size());
    report_and_finish(1'b1);
end

endmodule : tb_pipe_top

//--- pipe_top.f
src/pipe_pkg.sv
src/pipe_ifu.sv
src/pipe_idu.sv
src/pipe_exu.sv
src/pipe_wbu.sv
src/pipe_top.sv
sim/tb_clock.sv
sim/tb_pipe_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the pipeline testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_pipe_top -f pipe_top.f -o tb_pipe_top \
    && ./obj_dir/tb_pipe_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -qx "ALL CHECKS PASSED" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
